/* design/squeeze_defines.svh */
`ifndef SQUEEZE_DEFINES_SVH
`define SQUEEZE_DEFINES_SVH

////////////////////
// Layer geometry
////////////////////

// Output channels computed side by side
`define SQ_LANES 4

// Pixel, weight and output word width
`define SQ_DATA_W 16

// Accumulator and bias width
`define SQ_ACC_W 32

// Input channels per tap group
`define SQ_CHIN 8

// Kernel side, square window
`define SQ_KDIM 3

// Taps per output pixel, window times channels
`define SQ_TAPS (`SQ_KDIM * `SQ_KDIM * `SQ_CHIN)

// Output pixels before the layer ends
`define SQ_PIXELS 4

////////////////////
// Requantize
////////////////////

// Fixed point shift, result taken from acc[28:14]
`define SQ_FRAC 14

`endif

/* design/squeeze_pkg.sv */
`default_nettype none

`include "squeeze_defines.svh"

package squeeze_pkg;

	////////////////////
	// Scalar words
	////////////////////

	// Pixel, weight or requantized output
	typedef logic signed [`SQ_DATA_W-1:0] data_t;

	// Accumulator or bias
	typedef logic signed [`SQ_ACC_W-1:0] acc_t;

	// Tap index, doubles as ROM address
	typedef logic [$clog2(`SQ_TAPS)-1:0] tap_addr_t;

	// Output pixel count, must reach SQ_PIXELS
	typedef logic [$clog2(`SQ_PIXELS + 1)-1:0] pix_cnt_t;

	////////////////////
	// Lane vectors
	////////////////////

	typedef data_t [`SQ_LANES-1:0] weight_vec_t;
	typedef acc_t [`SQ_LANES-1:0] acc_vec_t;
	typedef data_t [`SQ_LANES-1:0] out_vec_t;

	// One accepted tap on its way to the MAC lanes
	typedef struct packed {
		logic  valid;
		logic  first;
		data_t pix;
	} mac_cmd_t;

	// Layer controller states
	typedef enum logic [2:0] {
		IDLE,
		TAP_WAIT,
		TAP_ACK,
		DRAIN,
		OUT_REQ,
		OUT_RELEASE,
		DONE
	} ctrl_state_t;

endpackage

`default_nettype wire

/* design/squeeze_ctrl.sv */
`default_nettype none

`include "squeeze_defines.svh"

module squeeze_ctrl (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   layer_req,
	input  wire logic                   pix_req,
	input  wire squeeze_pkg::data_t     pix,
	input  wire logic                   out_ack,
	output logic                        layer_ack,
	output logic                        pix_ack,
	output logic                        out_req,
	output squeeze_pkg::tap_addr_t      rom_addr,
	output squeeze_pkg::mac_cmd_t       mac_cmd,
	output logic                        load
);
	import squeeze_pkg::*;

	ctrl_state_t state;
	tap_addr_t   tap_cnt;
	pix_cnt_t    pix_cnt;
	// Second DRAIN cycle marker
	logic        drain_wait;

	////////////////////
	// Layer FSM
	////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state         <= IDLE;
			layer_ack     <= 1'b0;
			pix_ack       <= 1'b0;
			out_req       <= 1'b0;
			load          <= 1'b0;
			mac_cmd.valid <= 1'b0;
			rom_addr      <= '0;
			tap_cnt       <= '0;
			pix_cnt       <= '0;
			drain_wait    <= 1'b0;
		end else begin
			// Single cycle strobes
			mac_cmd.valid <= 1'b0;
			load          <= 1'b0;
			case (state)
				IDLE: begin
					if (layer_req) begin
						tap_cnt <= '0;
						pix_cnt <= '0;
						state   <= TAP_WAIT;
					end
				end
				TAP_WAIT: begin
					// Take the tap, send it to the lanes, look up its weights
					if (pix_req) begin
						pix_ack       <= 1'b1;
						mac_cmd.valid <= 1'b1;
						mac_cmd.first <= (tap_cnt == '0);
						mac_cmd.pix   <= pix;
						rom_addr      <= tap_cnt;
						tap_cnt       <= tap_cnt + 1'b1;
						state         <= TAP_ACK;
					end
				end
				TAP_ACK: begin
					// Host releases req before pix may change
					if (!pix_req) begin
						pix_ack <= 1'b0;
						if (tap_cnt == tap_addr_t'(`SQ_TAPS)) begin
							tap_cnt    <= '0;
							drain_wait <= 1'b0;
							state      <= DRAIN;
						end else begin
							state <= TAP_WAIT;
						end
					end
				end
				DRAIN: begin
					// ROM and MAC pipe settle, then load requant
					drain_wait <= 1'b1;
					if (drain_wait) begin
						load  <= 1'b1;
						state <= OUT_REQ;
					end
				end
				OUT_REQ: begin
					// out_req comes up with the result register
					if (out_ack) begin
						out_req <= 1'b0;
						state   <= OUT_RELEASE;
					end else begin
						out_req <= 1'b1;
					end
				end
				OUT_RELEASE: begin
					if (!out_ack) begin
						pix_cnt <= pix_cnt + 1'b1;
						if (pix_cnt == pix_cnt_t'(`SQ_PIXELS - 1)) begin
							layer_ack <= 1'b1;
							state     <= DONE;
						end else begin
							state <= TAP_WAIT;
						end
					end
				end
				DONE: begin
					if (!layer_req) begin
						layer_ack <= 1'b0;
						state     <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////
	// Checks
	////////////////////

	// Taps are held off while a result is offered
	a_no_ack_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(pix_ack && out_req));

	// Every MAC command comes from a tap taken in TAP_WAIT
	a_cmd_from_tap: assert property (@(posedge clk) disable iff (!rst_n)
		mac_cmd.valid |-> $past(state == TAP_WAIT && pix_req) && $rose(pix_ack));

endmodule

`default_nettype wire

/* design/coef_rom.sv */
`default_nettype none

`include "squeeze_defines.svh"

module coef_rom (
	input  wire logic                   clk,
	input  wire squeeze_pkg::tap_addr_t addr,
	output squeeze_pkg::weight_vec_t    weights,
	output squeeze_pkg::acc_vec_t       biases
);
	import squeeze_pkg::*;

	// One word per lane for each tap
	weight_vec_t rom_mem [0:`SQ_TAPS-1];

	////////////////////
	// Table fill
	////////////////////
	initial begin
		for (int t = 0; t < `SQ_TAPS; t++) begin
			for (int l = 0; l < `SQ_LANES; l++) begin
				// Spread of -30..30 over taps and lanes
				rom_mem[t][l] = data_t'(((t * 7 + l * 13) % 61) - 30);
			end
		end
	end

	// Registered read, word lands one cycle after addr
	always_ff @(posedge clk) begin
		weights <= rom_mem[addr];
	end

	// Bias per lane, scaled to the accumulator fixed point
	for (genvar l = 0; l < `SQ_LANES; l++) begin : g_bias
		assign biases[l] = acc_t'((l - 2) * 3 * (1 << `SQ_FRAC));
	end

	// Controller never steps past the last tap
	a_addr_range: assert property (@(posedge clk)
		!$isunknown(addr) |-> (addr < `SQ_TAPS));

endmodule

`default_nettype wire

/* design/mac_array.sv */
`default_nettype none

`include "squeeze_defines.svh"

module mac_array (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire squeeze_pkg::mac_cmd_t    cmd,
	input  wire squeeze_pkg::weight_vec_t weights,
	output squeeze_pkg::acc_vec_t         acc
);
	import squeeze_pkg::*;

	// Tap delayed to meet its ROM word
	mac_cmd_t cmd_d;
	// Lane products of the aligned tap
	acc_vec_t prod;

	////////////////////
	// Align stage
	////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd_d.valid <= 1'b0;
		end else begin
			cmd_d <= cmd;
		end
	end

	////////////////////
	// Multiply
	////////////////////
	always_comb begin
		for (int l = 0; l < `SQ_LANES; l++) begin
			// 16x16 signed, sign extended to full width first
			prod[l] = acc_t'(cmd_d.pix) * acc_t'($signed(weights[l]));
		end
	end

	////////////////////
	// Accumulate
	////////////////////
	always_ff @(posedge clk) begin
		if (cmd_d.valid) begin
			for (int l = 0; l < `SQ_LANES; l++) begin
				// First tap restarts the sum
				if (cmd_d.first) begin
					acc[l] <= prod[l];
				end else begin
					acc[l] <= acc[l] + prod[l];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/requant_relu.sv */
`default_nettype none

`include "squeeze_defines.svh"

module requant_relu (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   load,
	input  wire squeeze_pkg::acc_vec_t  acc,
	input  wire squeeze_pkg::acc_vec_t  biases,
	output squeeze_pkg::out_vec_t       result
);
	import squeeze_pkg::*;

	// Biased sums per lane
	acc_vec_t sum;

	////////////////////
	// Bias add
	////////////////////
	always_comb begin
		for (int l = 0; l < `SQ_LANES; l++) begin
			sum[l] = acc[l] + biases[l];
		end
	end

	////////////////////
	// ReLU and slice
	////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else if (load) begin
			for (int l = 0; l < `SQ_LANES; l++) begin
				// Negative clamps to zero
				if (sum[l][`SQ_ACC_W-1]) begin
					result[l] <= '0;
				end else begin
					// Top bits above 28 dropped, sign forced clear
					result[l] <= {1'b0, sum[l][`SQ_FRAC + `SQ_DATA_W - 2:`SQ_FRAC]};
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/squeeze_layer_top.sv */
`default_nettype none

module squeeze_layer_top (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                layer_req,
	input  wire logic                pix_req,
	input  wire squeeze_pkg::data_t  pix,
	input  wire logic                out_ack,
	output logic                     layer_ack,
	output logic                     pix_ack,
	output logic                     out_req,
	output squeeze_pkg::out_vec_t    result
);
	import squeeze_pkg::*;

	tap_addr_t   rom_addr;
	mac_cmd_t    mac_cmd;
	logic        load;
	weight_vec_t weights;
	acc_vec_t    biases;
	acc_vec_t    acc;

	////////////////////
	// Control
	////////////////////
	squeeze_ctrl ctrl_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.layer_req (layer_req),
		.pix_req   (pix_req),
		.pix       (pix),
		.out_ack   (out_ack),
		.layer_ack (layer_ack),
		.pix_ack   (pix_ack),
		.out_req   (out_req),
		.rom_addr  (rom_addr),
		.mac_cmd   (mac_cmd),
		.load      (load)
	);

	////////////////////
	// Datapath
	////////////////////
	coef_rom rom_i (
		.clk     (clk),
		.addr    (rom_addr),
		.weights (weights),
		.biases  (biases)
	);

	mac_array mac_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.cmd     (mac_cmd),
		.weights (weights),
		.acc     (acc)
	);

	// Doubles as the output holding register
	requant_relu rq_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.load   (load),
		.acc    (acc),
		.biases (biases),
		.result (result)
	);

endmodule

`default_nettype wire

/* verification/squeeze_tb.sv */
`default_nettype none

`include "squeeze_defines.svh"

module squeeze_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import squeeze_pkg::*;

	localparam int num_layers = 4;
	// Eight cycles per tap is generous, plus slack for reset and back-pressure
	localparam int cycle_limit = `SQ_PIXELS * `SQ_TAPS * 8 * num_layers + 2000;

	logic     clk;
	logic     rst_n;
	logic     layer_req;
	logic     pix_req;
	data_t    pix;
	logic     out_ack;
	logic     layer_ack;
	logic     pix_ack;
	logic     out_req;
	out_vec_t result;

	integer   seed;
	int       err_cnt;
	int       cycle_cnt;
	int       result_cnt;
	int       pending_cycles;
	logic     backpressure;
	logic     relu_mode;
	logic     out_req_q;
	logic     layer_ack_q;
	logic     holding;
	out_vec_t held_result;
	// Taps of the whole layer, in host order
	data_t    layer_pix [0:`SQ_PIXELS*`SQ_TAPS-1];
	data_t    window [0:`SQ_TAPS-1];

	squeeze_layer_top dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.layer_req (layer_req),
		.pix_req   (pix_req),
		.pix       (pix),
		.out_ack   (out_ack),
		.layer_ack (layer_ack),
		.pix_ack   (pix_ack),
		.out_req   (out_req),
		.result    (result)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////
	// Reference model
	////////////////////
	function automatic out_vec_t ref_result(input data_t taps [0:`SQ_TAPS-1]);
		out_vec_t r;
		int       sum;
		int       w;
		for (int l = 0; l < `SQ_LANES; l++) begin
			sum = 0;
			for (int t = 0; t < `SQ_TAPS; t++) begin
				w = ((t * 7 + l * 13) % 61) - 30;
				sum = sum + int'(taps[t]) * w;
			end
			// Bias is (l-2)*3 in output units
			sum = sum + (l - 2) * 3 * 16384;
			if (sum < 0) begin
				r[l] = '0;
			end else begin
				r[l] = {1'b0, sum[28:14]};
			end
		end
		return r;
	endfunction

	////////////////////
	// Host drivers
	////////////////////

	// Full handshake for one tap, entered and left just after a rising edge
	task automatic send_tap(input data_t value);
		pix     = value;
		pix_req = 1'b1;
		@(posedge clk);
		while (!pix_ack) @(posedge clk);
		#2 pix_req = 1'b0;
		@(posedge clk);
		while (pix_ack) @(posedge clk);
		#2;
	endtask

	task automatic fill_random_layer();
		for (int i = 0; i < `SQ_PIXELS * `SQ_TAPS; i++) begin
			layer_pix[i] = data_t'($random(seed));
		end
	endtask

	// Small taps, bias dominates so lanes 0 and 1 go negative
	task automatic fill_small_layer();
		for (int i = 0; i < `SQ_PIXELS * `SQ_TAPS; i++) begin
			layer_pix[i] = data_t'($random(seed) % 8);
		end
	endtask

	task automatic run_layer(input logic bp, input logic relu);
		backpressure   = bp;
		relu_mode      = relu;
		result_cnt     = 0;
		pending_cycles = 0;
		@(posedge clk);
		#2 layer_req = 1'b1;
		for (int i = 0; i < `SQ_PIXELS * `SQ_TAPS; i++) begin
			send_tap(layer_pix[i]);
		end
		@(posedge clk);
		while (!layer_ack) @(posedge clk);
		if (result_cnt != `SQ_PIXELS) begin
			$display("ERROR at %0t: %0d results in layer, expected %0d",
				$time, result_cnt, `SQ_PIXELS);
			err_cnt++;
		end
		if (bp && pending_cycles == 0) begin
			$display("Back-pressure layer never held a tap request during an output offer");
			err_cnt++;
		end
		#2 layer_req = 1'b0;
		@(posedge clk);
		while (layer_ack) @(posedge clk);
	endtask

	// Result side, optional random delay before ack
	initial begin : out_responder
		int delay;
		forever begin
			@(posedge clk);
			if (out_req && !out_ack) begin
				delay = backpressure ? ($unsigned($random(seed)) % 16) : 0;
				repeat (delay) @(posedge clk);
				#2 out_ack = 1'b1;
				@(posedge clk);
				while (out_req) @(posedge clk);
				#2 out_ack = 1'b0;
			end
		end
	end

	////////////////////
	// Comparison
	////////////////////
	always @(posedge clk) begin : compare_results
		out_vec_t expected;
		int       base;
		out_req_q   <= out_req;
		layer_ack_q <= layer_ack;
		if (!rst_n) begin
			holding <= 1'b0;
		end else begin
			if (out_req && !out_req_q) begin
				if (result_cnt >= `SQ_PIXELS) begin
					$display("Result offered after all pixels of the layer were done");
					err_cnt++;
				end else begin
					base = result_cnt * `SQ_TAPS;
					for (int t = 0; t < `SQ_TAPS; t++) begin
						window[t] = layer_pix[base + t];
					end
					expected = ref_result(window);
					for (int l = 0; l < `SQ_LANES; l++) begin
						if (result[l] !== expected[l]) begin
							$display("ERROR at %0t: pixel %0d lane %0d got %0d expected %0d",
								$time, result_cnt, l, result[l], expected[l]);
							err_cnt++;
						end
						// Negative bias lanes must clamp
						if (relu_mode && l < 2 && result[l] !== '0) begin
							$display("ERROR at %0t: lane %0d not clamped to zero", $time, l);
							err_cnt++;
						end
					end
				end
				result_cnt++;
				held_result <= result;
				holding     <= 1'b1;
			end else if (holding) begin
				if (result !== held_result) begin
					$display("ERROR at %0t: result changed during output handshake", $time);
					err_cnt++;
				end
				if (!out_req && !out_ack) holding <= 1'b0;
			end
			if (pix_ack && out_req) begin
				$display("ERROR at %0t: pix_ack while out_req is high", $time);
				err_cnt++;
			end
			if (pix_req && out_req) pending_cycles++;
			if (layer_ack && !layer_ack_q && (result_cnt != `SQ_PIXELS || out_ack)) begin
				$display("ERROR at %0t: layer_ack before last output handshake", $time);
				err_cnt++;
			end
			// Layer ack holds until the host lets go of its request
			if (!layer_ack && layer_ack_q && layer_req) begin
				$display("ERROR at %0t: layer_ack dropped while layer_req high", $time);
				err_cnt++;
			end
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout, the run did not finish within %0d cycles", cycle_limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////
	// Test sequence
	////////////////////
	initial begin
		seed      = 19;
		err_cnt   = 0;
		cycle_cnt = 0;
		rst_n     = 1'b0;
		layer_req = 1'b0;
		pix_req   = 1'b0;
		pix       = '0;
		out_ack   = 1'b0;
		backpressure = 1'b0;
		relu_mode    = 1'b0;
		repeat (8) @(posedge clk);
		#2 rst_n = 1'b1;
		// Idle after reset, a tap request alone is ignored
		@(posedge clk);
		if (layer_ack || pix_ack || out_req) begin
			$display("ERROR at %0t: handshake outputs not low after reset", $time);
			err_cnt++;
		end
		#2 pix = 16'sd5;
		pix_req = 1'b1;
		repeat (10) begin
			@(posedge clk);
			if (pix_ack) begin
				$display("ERROR at %0t: pix_ack without layer_req", $time);
				err_cnt++;
			end
		end
		#2 pix_req = 1'b0;
		fill_random_layer();
		run_layer(1'b0, 1'b0);
		fill_small_layer();
		run_layer(1'b0, 1'b1);
		fill_random_layer();
		run_layer(1'b1, 1'b0);
		// Back to back layer, counters and sums restart
		fill_random_layer();
		run_layer(1'b0, 1'b0);
		repeat (4) @(posedge clk);
		$display("Run complete, %0d errors", err_cnt);
		if (err_cnt == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/squeeze_pkg.sv
design/squeeze_ctrl.sv
design/coef_rom.sv
design/mac_array.sv
design/requant_relu.sv
design/squeeze_layer_top.sv
verification/squeeze_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = squeeze_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
